/* tdc_params.svh */
`ifndef TDC_PARAMS_SVH
`define TDC_PARAMS_SVH

// sample and angle width.
`define TDC_DATA_W 16

// line memory geometry.
`define TDC_ADDR_W 11
`define TDC_DEPTH 2048

// spike filter tolerance.
`define TDC_SPIKE_TOL 5

// rise values at or above this are invalid.
`define TDC_RISE_MAX 8000

// idle cycles between replayed entries.
`define TDC_GAP_CYCLES 400

// frame end per resolution mode.
`define TDC_FRAME_END_0 1755
`define TDC_FRAME_END_1 1404
`define TDC_FRAME_END_2 1053
`define TDC_FRAME_END_3 702

`endif

/* tdc_pkg.sv */
package tdc_pkg;

	// rise or fall time from the TDC.
	typedef logic [15:0] tdc_time_t;

	// encoder angle code.
	typedef logic [15:0] angle_code_t;

	// line memory address.
	typedef logic [10:0] line_addr_t;

	// resolution mode select.
	typedef logic [1:0] reso_mode_t;

	// replay pacing counter.
	typedef logic [15:0] gap_cnt_t;

	// replay controller states.
	typedef enum logic [2:0] {
		IDLE,
		READ,
		ASSIGN,
		SIG,
		GAP,
		REARM
	} replay_state_t;

endpackage

/* tdc_sample_if.sv */
`timescale 1ns/100ps

interface tdc_sample_if;

	logic                 wren;
	tdc_pkg::line_addr_t  addr;
	tdc_pkg::tdc_time_t   rise;
	tdc_pkg::tdc_time_t   fall;

	modport source (
		output wren,
		output addr,
		output rise,
		output fall
	);

	modport sink (
		input wren,
		input addr,
		input rise,
		input fall
	);

endinterface

/* tdc_capture.sv */
`timescale 1ns/100ps

`include "tdc_params.svh"

module tdc_capture (
	input  logic                 i_clk_50m,
	input  logic                 i_rst_n,
	input  logic                 i_tdc_new_sig,
	input  tdc_pkg::angle_code_t i_code_angle,
	input  tdc_pkg::tdc_time_t   i_rise_data,
	input  tdc_pkg::tdc_time_t   i_fall_data,
	tdc_sample_if.source         wr
);

	tdc_pkg::tdc_time_t r_rise_s0;
	tdc_pkg::tdc_time_t r_rise_s1;
	tdc_pkg::tdc_time_t r_rise_s2;
	tdc_pkg::tdc_time_t r_fall_s0;
	tdc_pkg::tdc_time_t r_fall_s1;
	tdc_pkg::tdc_time_t r_diff_02;
	tdc_pkg::tdc_time_t r_diff_10;
	logic               r_sig_d1;
	logic               r_sig_d2;

	// history shift, newest first.
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_rise_s0 <= '0;
			r_rise_s1 <= '0;
			r_rise_s2 <= '0;
			r_fall_s0 <= '0;
			r_fall_s1 <= '0;
			wr.addr   <= '0;
		end else if (i_tdc_new_sig) begin
			r_rise_s0 <= i_rise_data;
			r_rise_s1 <= r_rise_s0;
			r_rise_s2 <= r_rise_s1;
			r_fall_s0 <= i_fall_data;
			r_fall_s1 <= r_fall_s0;
			// s1 belongs to the previous angle.
			wr.addr   <= i_code_angle[`TDC_ADDR_W-1:0] - 1'b1;
		end
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_sig_d1 <= 1'b0;
			r_sig_d2 <= 1'b0;
			wr.wren  <= 1'b0;
		end else begin
			r_sig_d1 <= i_tdc_new_sig;
			r_sig_d2 <= r_sig_d1;
			wr.wren  <= r_sig_d2;
		end
	end

	// neighbour differences.
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_diff_02 <= '0;
			r_diff_10 <= '0;
		end else if (r_sig_d1) begin
			r_diff_02 <= (r_rise_s0 >= r_rise_s2) ?
				r_rise_s0 - r_rise_s2 : r_rise_s2 - r_rise_s0;
			r_diff_10 <= (r_rise_s1 >= r_rise_s0) ?
				r_rise_s1 - r_rise_s0 : r_rise_s0 - r_rise_s1;
		end
	end

	// smooth neighbourhood keeps the older sample.
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr.rise <= '0;
			wr.fall <= '0;
		end else if (r_sig_d2) begin
			if (r_diff_02 <= `TDC_SPIKE_TOL && r_diff_10 <= `TDC_SPIKE_TOL)
				wr.rise <= r_rise_s2;
			else
				wr.rise <= r_rise_s1;
			wr.fall <= r_fall_s1;
		end
	end

endmodule

/* tdc_line_ram.sv */
`timescale 1ns/100ps

`include "tdc_params.svh"

module tdc_line_ram (
	input  logic                i_clk_50m,
	tdc_sample_if.sink          wr,
	input  tdc_pkg::line_addr_t i_rd_addr,
	output tdc_pkg::tdc_time_t  o_rd_rise,
	output tdc_pkg::tdc_time_t  o_rd_fall
);

	tdc_pkg::tdc_time_t mem_rise [0:`TDC_DEPTH-1];
	tdc_pkg::tdc_time_t mem_fall [0:`TDC_DEPTH-1];

	// both halves share the write address.
	always_ff @(posedge i_clk_50m) begin
		if (wr.wren) begin
			mem_rise[wr.addr] <= wr.rise;
			mem_fall[wr.addr] <= wr.fall;
		end
	end

	// read data follows the address by one cycle.
	always_ff @(posedge i_clk_50m) begin
		o_rd_rise <= mem_rise[i_rd_addr];
		o_rd_fall <= mem_fall[i_rd_addr];
	end

endmodule

/* tdc_replay_ctrl.sv */
`timescale 1ns/100ps

`include "tdc_params.svh"

module tdc_replay_ctrl (
	input  logic                 i_clk_50m,
	input  logic                 i_rst_n,
	input  tdc_pkg::angle_code_t i_code_angle,
	input  tdc_pkg::reso_mode_t  i_reso_mode,
	output tdc_pkg::line_addr_t  o_rd_addr,
	input  tdc_pkg::tdc_time_t   i_rd_rise,
	input  tdc_pkg::tdc_time_t   i_rd_fall,
	output tdc_pkg::angle_code_t o_code_angle,
	output logic                 o_cal_sig,
	output tdc_pkg::tdc_time_t   o_rise_data,
	output tdc_pkg::tdc_time_t   o_fall_data
);

	tdc_pkg::replay_state_t r_state;
	tdc_pkg::angle_code_t   w_frame_end;
	tdc_pkg::angle_code_t   r_frame_end;
	tdc_pkg::line_addr_t    r_last_addr;
	tdc_pkg::gap_cnt_t      r_gap_cnt;
	tdc_pkg::tdc_time_t     r_hold_rise;
	tdc_pkg::tdc_time_t     r_hold_fall;
	logic                   w_rd_valid;

	always_comb begin
		case (i_reso_mode)
			2'd0:    w_frame_end = `TDC_FRAME_END_0;
			2'd1:    w_frame_end = `TDC_FRAME_END_1;
			2'd2:    w_frame_end = `TDC_FRAME_END_2;
			default: w_frame_end = `TDC_FRAME_END_3;
		endcase
	end

	assign w_rd_valid = (i_rd_rise != '0) && (i_rd_rise != 16'hFFFF) &&
		(i_rd_rise < `TDC_RISE_MAX);

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state      <= tdc_pkg::IDLE;
			r_frame_end  <= '0;
			r_last_addr  <= '0;
			r_gap_cnt    <= '0;
			r_hold_rise  <= '0;
			r_hold_fall  <= '0;
			o_rd_addr    <= '0;
			o_code_angle <= '0;
			o_cal_sig    <= 1'b0;
			o_rise_data  <= '0;
			o_fall_data  <= '0;
		end else begin
			o_cal_sig <= 1'b0;
			case (r_state)
				tdc_pkg::IDLE: begin
					o_rd_addr   <= '0;
					r_hold_rise <= '0;
					r_hold_fall <= '0;
					// latch the frame so a mode change waits for the next one.
					if (i_code_angle >= w_frame_end) begin
						r_frame_end <= w_frame_end;
						r_last_addr <= w_frame_end[`TDC_ADDR_W-1:0] - 1'b1;
						r_state     <= tdc_pkg::READ;
					end
				end
				tdc_pkg::READ:
					r_state <= tdc_pkg::ASSIGN;
				tdc_pkg::ASSIGN: begin
					o_code_angle <= tdc_pkg::angle_code_t'(o_rd_addr);
					o_cal_sig    <= 1'b1;
					if (w_rd_valid) begin
						o_rise_data <= i_rd_rise;
						o_fall_data <= i_rd_fall;
						r_hold_rise <= i_rd_rise;
						r_hold_fall <= i_rd_fall;
					end else begin
						// repeat the last good entry.
						o_rise_data <= r_hold_rise;
						o_fall_data <= r_hold_fall;
					end
					r_state <= tdc_pkg::SIG;
				end
				tdc_pkg::SIG: begin
					r_gap_cnt <= '0;
					if (o_rd_addr == r_last_addr) begin
						r_state <= tdc_pkg::REARM;
					end else begin
						o_rd_addr <= o_rd_addr + 1'b1;
						r_state   <= tdc_pkg::GAP;
					end
				end
				tdc_pkg::GAP: begin
					if (r_gap_cnt == `TDC_GAP_CYCLES - 1) begin
						r_gap_cnt <= '0;
						r_state   <= tdc_pkg::READ;
					end else begin
						r_gap_cnt <= r_gap_cnt + 1'b1;
					end
				end
				tdc_pkg::REARM:
					if (i_code_angle < r_frame_end)
						r_state <= tdc_pkg::IDLE;
				default:
					r_state <= tdc_pkg::IDLE;
			endcase
		end
	end

endmodule

/* angle_seq_monitor.sv */
`timescale 1ns/100ps

`include "tdc_params.svh"

module angle_seq_monitor (
	input  logic                 i_clk_50m,
	input  logic                 i_rst_n,
	input  logic                 i_strobe,
	input  tdc_pkg::angle_code_t i_angle,
	input  tdc_pkg::angle_code_t i_start_index,
	input  tdc_pkg::angle_code_t i_stop_index,
	output logic                 o_error,
	output tdc_pkg::angle_code_t o_last_code,
	output tdc_pkg::angle_code_t o_current_code
);

	logic                 r_strobe;
	logic                 r_in_win;
	logic                 r_first;
	tdc_pkg::angle_code_t r_angle;
	tdc_pkg::angle_code_t r_prev;
	logic                 w_break;

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_strobe <= 1'b0;
			r_in_win <= 1'b0;
			r_angle  <= '0;
		end else begin
			r_strobe <= i_strobe;
			r_in_win <= (i_angle >= i_start_index) && (i_angle <= i_stop_index);
			r_angle  <= i_angle;
		end
	end

	// the first checked strobe only seeds the sequence.
	assign w_break = r_strobe && r_in_win && !r_first &&
		(r_angle != r_prev + `TDC_DATA_W'(1));

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_first        <= 1'b1;
			r_prev         <= '0;
			o_error        <= 1'b0;
			o_last_code    <= '0;
			o_current_code <= '0;
		end else begin
			if (r_strobe)
				r_prev <= r_angle;
			if (r_strobe && r_in_win)
				r_first <= 1'b0;
			if (w_break) begin
				o_error <= 1'b1;
				// keep only the first break.
				if (!o_error) begin
					o_last_code    <= r_prev;
					o_current_code <= r_angle;
				end
			end
		end
	end

endmodule

/* tdc_process.sv */
`timescale 1ns/100ps

module tdc_process (
	input  logic                 i_clk_50m,
	input  logic                 i_rst_n,
	input  tdc_pkg::angle_code_t i_code_angle,
	input  logic                 i_tdc_new_sig,
	input  tdc_pkg::tdc_time_t   i_rise_data,
	input  tdc_pkg::tdc_time_t   i_fall_data,
	input  tdc_pkg::reso_mode_t  i_reso_mode,
	input  tdc_pkg::angle_code_t i_start_index,
	input  tdc_pkg::angle_code_t i_stop_index,
	input  logic                 i_tdc_switch,
	output tdc_pkg::angle_code_t o_code_angle,
	output logic                 o_cal_sig,
	output tdc_pkg::tdc_time_t   o_rise_data,
	output tdc_pkg::tdc_time_t   o_fall_data,
	output logic [1:0]           o_tdc_process_error,
	output tdc_pkg::angle_code_t o_error_last_code,
	output tdc_pkg::angle_code_t o_error_current_code
);

	tdc_pkg::line_addr_t  w_rd_addr;
	tdc_pkg::tdc_time_t   w_rd_rise;
	tdc_pkg::tdc_time_t   w_rd_fall;
	tdc_pkg::angle_code_t w_rep_code_angle;
	logic                 w_rep_cal_sig;
	tdc_pkg::tdc_time_t   w_rep_rise;
	tdc_pkg::tdc_time_t   w_rep_fall;
	logic                 w_in_error;
	logic                 w_out_error;

	tdc_sample_if u_sample_if ();

	tdc_capture u_capture (
		.i_clk_50m     (i_clk_50m),
		.i_rst_n       (i_rst_n),
		.i_tdc_new_sig (i_tdc_new_sig),
		.i_code_angle  (i_code_angle),
		.i_rise_data   (i_rise_data),
		.i_fall_data   (i_fall_data),
		.wr            (u_sample_if.source)
	);

	tdc_line_ram u_line_ram (
		.i_clk_50m (i_clk_50m),
		.wr        (u_sample_if.sink),
		.i_rd_addr (w_rd_addr),
		.o_rd_rise (w_rd_rise),
		.o_rd_fall (w_rd_fall)
	);

	tdc_replay_ctrl u_replay_ctrl (
		.i_clk_50m    (i_clk_50m),
		.i_rst_n      (i_rst_n),
		.i_code_angle (i_code_angle),
		.i_reso_mode  (i_reso_mode),
		.o_rd_addr    (w_rd_addr),
		.i_rd_rise    (w_rd_rise),
		.i_rd_fall    (w_rd_fall),
		.o_code_angle (w_rep_code_angle),
		.o_cal_sig    (w_rep_cal_sig),
		.o_rise_data  (w_rep_rise),
		.o_fall_data  (w_rep_fall)
	);

	// bypass passes the raw stream straight through.
	assign o_code_angle = i_tdc_switch ? w_rep_code_angle : i_code_angle;
	assign o_cal_sig    = i_tdc_switch ? w_rep_cal_sig : i_tdc_new_sig;
	assign o_rise_data  = i_tdc_switch ? w_rep_rise : i_rise_data;
	assign o_fall_data  = i_tdc_switch ? w_rep_fall : i_fall_data;

	angle_seq_monitor u_in_mon (
		.i_clk_50m      (i_clk_50m),
		.i_rst_n        (i_rst_n),
		.i_strobe       (i_tdc_new_sig),
		.i_angle        (i_code_angle),
		.i_start_index  (i_start_index),
		.i_stop_index   (i_stop_index),
		.o_error        (w_in_error),
		.o_last_code    (),
		.o_current_code ()
	);

	// watches whatever stream leaves the block.
	angle_seq_monitor u_out_mon (
		.i_clk_50m      (i_clk_50m),
		.i_rst_n        (i_rst_n),
		.i_strobe       (o_cal_sig),
		.i_angle        (o_code_angle),
		.i_start_index  (i_start_index),
		.i_stop_index   (i_stop_index),
		.o_error        (w_out_error),
		.o_last_code    (o_error_last_code),
		.o_current_code (o_error_current_code)
	);

	assign o_tdc_process_error = {w_out_error, w_in_error};

endmodule

/* tb_tdc_process.sv */
`timescale 1ns/100ps

`include "tdc_params.svh"

module tb_tdc_process;

	localparam int STROBE_GAP    = 6;
	localparam int PULSE_TIMEOUT = 1000;

	logic                 i_clk_50m;
	logic                 i_rst_n;
	tdc_pkg::angle_code_t i_code_angle;
	logic                 i_tdc_new_sig;
	tdc_pkg::tdc_time_t   i_rise_data;
	tdc_pkg::tdc_time_t   i_fall_data;
	tdc_pkg::reso_mode_t  i_reso_mode;
	tdc_pkg::angle_code_t i_start_index;
	tdc_pkg::angle_code_t i_stop_index;
	logic                 i_tdc_switch;
	tdc_pkg::angle_code_t o_code_angle;
	logic                 o_cal_sig;
	tdc_pkg::tdc_time_t   o_rise_data;
	tdc_pkg::tdc_time_t   o_fall_data;
	logic [1:0]           o_tdc_process_error;
	tdc_pkg::angle_code_t o_error_last_code;
	tdc_pkg::angle_code_t o_error_current_code;

	// expected memory contents and filter history.
	int mem_rise [0:`TDC_DEPTH-1];
	int mem_fall [0:`TDC_DEPTH-1];
	int hist_rise [0:2];
	int hist_fall [0:1];
	int exp_q_rise [$];
	int exp_q_fall [$];
	int base_rise;
	int seed;

	tdc_process UUT (.*);

	always #10 i_clk_50m = ~i_clk_50m;

	task automatic value_error(input string name, input int exp_val, input int act_val);
		$display("ERR %s expected %0d actual %0d", name, exp_val, act_val);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic run_error(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1);
	endtask

	function automatic int abs_diff(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	// random walk with level steps, lone spikes and two invalid angles.
	task automatic make_sample(input int angle, output int rise, output int fall);
		base_rise = base_rise + ($random(seed) & 3) - 1;
		if (($random(seed) & 31) == 0)
			base_rise = base_rise + 700;
		if (base_rise > 7000)
			base_rise = 1500;
		rise = base_rise;
		if (($random(seed) & 15) == 1)
			rise = base_rise + 250;
		if (angle == 100)
			rise = 0;
		else if (angle == 200)
			rise = 9000;
		fall = rise + 40 + ($random(seed) & 15);
	endtask

	task automatic send_strobe(input int angle);
		int rise;
		int fall;
		int addr;
		make_sample(angle, rise, fall);
		repeat (STROBE_GAP - 1) @(posedge i_clk_50m);
		i_code_angle  <= tdc_pkg::angle_code_t'(angle);
		i_tdc_new_sig <= 1'b1;
		i_rise_data   <= tdc_pkg::tdc_time_t'(rise);
		i_fall_data   <= tdc_pkg::tdc_time_t'(fall);
		hist_rise[2] = hist_rise[1];
		hist_rise[1] = hist_rise[0];
		hist_rise[0] = rise;
		hist_fall[1] = hist_fall[0];
		hist_fall[0] = fall;
		// the strobe of angle k+1 stores the sample of angle k.
		addr = (angle - 1) & (`TDC_DEPTH - 1);
		if (abs_diff(hist_rise[0], hist_rise[2]) <= `TDC_SPIKE_TOL &&
			abs_diff(hist_rise[1], hist_rise[0]) <= `TDC_SPIKE_TOL)
			mem_rise[addr] = hist_rise[2];
		else
			mem_rise[addr] = hist_rise[1];
		mem_fall[addr] = hist_fall[1];
		@(posedge i_clk_50m);
		i_tdc_new_sig <= 1'b0;
	endtask

	task automatic send_range(input int first, input int last, input int skip);
		for (int a = first; a <= last; a++) begin
			if (a != skip)
				send_strobe(a);
		end
	endtask

	// replay order with invalid entries replaced by the last good one.
	task automatic build_expected(input int count);
		int hold_rise;
		int hold_fall;
		hold_rise = 0;
		hold_fall = 0;
		exp_q_rise.delete();
		exp_q_fall.delete();
		for (int k = 0; k < count; k++) begin
			if (mem_rise[k] != 0 && mem_rise[k] != 16'hFFFF &&
				mem_rise[k] < `TDC_RISE_MAX) begin
				hold_rise = mem_rise[k];
				hold_fall = mem_fall[k];
			end
			exp_q_rise.push_back(hold_rise);
			exp_q_fall.push_back(hold_fall);
		end
	endtask

	task automatic wait_cal_pulse(input string name);
		int cycles;
		cycles = 0;
		@(negedge i_clk_50m);
		while (!o_cal_sig && cycles < PULSE_TIMEOUT) begin
			cycles++;
			@(negedge i_clk_50m);
		end
		if (!o_cal_sig)
			run_error({name, ": timed out waiting for a replay strobe"});
	endtask

	task automatic check_replay(input string name, input int count);
		int exp_r;
		int exp_f;
		for (int n = 0; n < count; n++) begin
			wait_cal_pulse(name);
			exp_r = exp_q_rise.pop_front();
			exp_f = exp_q_fall.pop_front();
			assert (o_code_angle == n) else value_error({name, " angle"}, n, o_code_angle);
			assert (o_rise_data == exp_r) else value_error({name, " rise"}, exp_r, o_rise_data);
			assert (o_fall_data == exp_f) else value_error({name, " fall"}, exp_f, o_fall_data);
		end
		for (int c = 0; c < PULSE_TIMEOUT; c++) begin
			@(negedge i_clk_50m);
			assert (!o_cal_sig) else run_error({name, ": replay strobe after the last entry"});
		end
	endtask

	task automatic check_flags(input string name, input int exp_err, input int exp_last,
		input int exp_cur);
		repeat (3) @(negedge i_clk_50m);
		assert (o_tdc_process_error == exp_err)
			else value_error({name, " error"}, exp_err, o_tdc_process_error);
		assert (o_error_last_code == exp_last)
			else value_error({name, " last code"}, exp_last, o_error_last_code);
		assert (o_error_current_code == exp_cur)
			else value_error({name, " current code"}, exp_cur, o_error_current_code);
	endtask

	// bypass outputs follow the inputs in the same cycle.
	always @(negedge i_clk_50m) begin
		if (i_rst_n && !i_tdc_switch) begin
			assert (o_cal_sig == i_tdc_new_sig)
				else value_error("bypass strobe", i_tdc_new_sig, o_cal_sig);
			assert (o_code_angle == i_code_angle)
				else value_error("bypass angle", i_code_angle, o_code_angle);
			assert (o_rise_data == i_rise_data)
				else value_error("bypass rise", i_rise_data, o_rise_data);
			assert (o_fall_data == i_fall_data)
				else value_error("bypass fall", i_fall_data, o_fall_data);
		end
	end

	// a replay strobe lasts one cycle.
	assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		(i_tdc_switch && o_cal_sig) |=> !o_cal_sig)
		else run_error("replay strobe held high for more than one cycle");

	// error flags stay set until reset.
	assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		o_tdc_process_error[0] |=> o_tdc_process_error[0])
		else run_error("input break flag cleared without a reset");

	assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		o_tdc_process_error[1] |=> o_tdc_process_error[1])
		else run_error("output break flag cleared without a reset");

	initial begin
		seed          = 66193;
		base_rise     = 3000;
		hist_rise     = '{0, 0, 0};
		hist_fall     = '{0, 0};
		i_clk_50m     = 1'b0;
		i_rst_n       = 1'b0;
		i_code_angle  = '0;
		i_tdc_new_sig = 1'b0;
		i_rise_data   = '0;
		i_fall_data   = '0;
		i_reso_mode   = 2'd3;
		i_start_index = 16'd10;
		i_stop_index  = 16'd600;
		i_tdc_switch  = 1'b1;
		repeat (10) @(posedge i_clk_50m);
		i_rst_n <= 1'b1;
		@(negedge i_clk_50m);
		assert (o_cal_sig == 1'b0) else value_error("reset strobe", 0, o_cal_sig);
		assert (o_code_angle == 0) else value_error("reset angle", 0, o_code_angle);
		assert (o_rise_data == 0) else value_error("reset rise", 0, o_rise_data);
		assert (o_fall_data == 0) else value_error("reset fall", 0, o_fall_data);
		check_flags("reset", 0, 0, 0);

		// skip below the window leaves both flags clear.
		@(posedge i_clk_50m);
		i_tdc_switch <= 1'b0;
		send_range(0, 15, 4);
		check_flags("outside skip", 0, 0, 0);

		@(posedge i_clk_50m);
		i_tdc_switch <= 1'b1;
		send_range(0, `TDC_FRAME_END_3, -1);
		build_expected(`TDC_FRAME_END_3);
		check_replay("mode 3 replay", `TDC_FRAME_END_3);
		check_flags("mode 3 frame", 0, 0, 0);

		// skip inside the window in bypass, then a mode 2 frame.
		@(posedge i_clk_50m);
		i_tdc_switch <= 1'b0;
		i_reso_mode  <= 2'd2;
		send_range(0, 99, 51);
		check_flags("inside skip", 3, 50, 52);
		@(posedge i_clk_50m);
		i_tdc_switch <= 1'b1;
		send_range(100, `TDC_FRAME_END_2, -1);
		build_expected(`TDC_FRAME_END_2);
		check_replay("mode 2 replay", `TDC_FRAME_END_2);

		$display("all tests passed");
		$finish;
	end

endmodule

/* build.f */
+incdir+.
tdc_pkg.sv
tdc_sample_if.sv
tdc_capture.sv
tdc_line_ram.sv
tdc_replay_ctrl.sv
angle_seq_monitor.sv
tdc_process.sv
tb_tdc_process.sv

/* Makefile */
TOP := tb_tdc_process

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build output"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
